/* compile.f */
+incdir+.
hif_pkg.sv
hif_arbiter.sv
hif_link.sv
hif_rx_path.sv
hif_tx_path.sv
hif_top.sv
tb_hif.sv

/* hif_arbiter.sv */
`timescale 1ns/1ps

module hif_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  hif_pkg::sched_t sched,
    input  logic            cfg_req,
    input  logic            done,
    output hif_pkg::xfer_t  xfer,
    output hif_pkg::sched_t sched_lev,
    output logic            issue
);
    import hif_pkg::*;

    localparam int NUM_STR = 7;

    // Bit 0 is cfg and has the highest priority
    logic [NUM_STR-1:0] pend;
    logic [NUM_STR-1:0] pend_set;
    logic [NUM_STR-1:0] pend_clr;
    logic [NUM_STR-1:0] pick_oh;
    stream_e            pick_str;
    logic               wei_ev;
    logic               act_ev;
    logic               start;
    sched_t             lev_q;

    function automatic stream_e idx_to_stream(input int idx);
        case (idx)
            0:       return STR_CFG;
            1:       return STR_FLGWEI;
            2:       return STR_WEI;
            3:       return STR_FLGACT;
            4:       return STR_ACT;
            5:       return STR_FLGOFM;
            default: return STR_OFM;
        endcase
    endfunction

    // ==================================================================
    // Pending flags and priority pick
    // ==================================================================
    assign wei_ev   = sched.reset_ftrgrp | sched.next_ftrgrp;
    assign act_ev   = sched.reset_patch | sched.next_patch;
    assign pend_set = {sched.reset_ofm, sched.reset_ofm, act_ev, act_ev,
                       wei_ev, wei_ev, cfg_req};

    // Lowest set index wins
    always_comb begin
        pick_oh  = '0;
        pick_str = STR_CFG;
        for (int i = NUM_STR - 1; i >= 0; i--) begin
            if (pend[i]) begin
                pick_oh    = '0;
                pick_oh[i] = 1'b1;
                pick_str   = idx_to_stream(i);
            end
        end
    end

    assign start    = !xfer.active && (|pend);
    assign pend_clr = start ? pick_oh : '0;

    // ==================================================================
    // Transfer state
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend  <= '0;
            issue <= 1'b0;
            xfer  <= '0;
        end else begin
            pend  <= (pend & ~pend_clr) | pend_set;
            issue <= start;
            if (start) begin
                xfer.active <= 1'b1;
                xfer.dir    <= !(pick_str inside {STR_FLGOFM, STR_OFM});
                xfer.stream <= pick_str;
            end else if (done) begin
                xfer.active <= 1'b0;
            end
        end
    end

    // Reset events stay up until the next command goes out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lev_q <= '0;
        end else if (issue) begin
            lev_q <= sched;
        end else begin
            lev_q <= lev_q | sched;
        end
    end

    assign sched_lev = sched | lev_q;

endmodule

/* hif_defines.svh */
`ifndef HIF_DEFINES_SVH
`define HIF_DEFINES_SVH

// ======================================================================
// Host interface widths
// ======================================================================

// Host port and buffer word width
`define HIF_DATA_W    16

// Global buffer address width
`define GBF_ADDR_W    8

// Fixed number of words in one transfer
`define HIF_BURST_LEN 8

`endif

/* hif_link.sv */
`timescale 1ns/1ps
`include "hif_defines.svh"

module hif_link (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hif_pkg::xfer_t         xfer,
    input  logic                   issue,
    input  logic                   host_rx_valid,
    input  logic [`HIF_DATA_W-1:0] tx_word,
    input  logic                   tx_valid,
    output logic                   host_req,
    output hif_pkg::host_word_u    host_tx_data,
    output logic                   host_tx_valid,
    output logic                   done
);
    import hif_pkg::*;

    localparam int CNT_W = $clog2(`HIF_BURST_LEN + 1);

    host_cmd_t        cmd_word;
    logic [CNT_W-1:0] word_cnt;
    logic             in_move;
    logic             out_move;
    logic             move;

    assign cmd_word = '{dir: xfer.dir, stream: xfer.stream, len: 11'(`HIF_BURST_LEN)};

    // ==================================================================
    // Word counting
    // ==================================================================
    // No inbound word is taken while the command is on the bus
    assign in_move  = xfer.active && xfer.dir && !issue && host_rx_valid;
    assign out_move = xfer.active && !xfer.dir && tx_valid;
    assign move     = in_move || out_move;
    assign done     = move && (word_cnt == CNT_W'(`HIF_BURST_LEN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (issue) begin
            word_cnt <= '0;
        end else if (move) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Outbound bus
    // ==================================================================
    assign host_req      = issue;
    assign host_tx_valid = out_move;

    // Command and ofm data share the same word
    always_comb begin
        host_tx_data = '0;
        if (issue) begin
            host_tx_data.cmd = cmd_word;
        end else if (out_move) begin
            host_tx_data.raw = tx_word;
        end
    end

endmodule

/* hif_patterns.txt */
# T test_id sched cfg_req  (sched bits: next_patch next_ftrgrp reset_patch reset_ftrgrp reset_ofm)
# S stream w0 .. w7  (expected stream code, eight words for inbound streams only, all hex)
T 1 00 1
S 0 c100 c101 c102 c103 c104 c105 c106 c107
T 2 02 0
S 8 00ff 0f0f 3c3c 5555 aaaa ffff 0001 8000
S 6 1234 2345 3456 4567 5678 6789 789a 89ab
T 3 08 0
S 8 f001 f002 f004 f008 f010 f020 f040 f080
S 6 9abc abcd bcde cdef def0 ef01 f012 0123
T 4 10 0
S 4 4a00 4a11 4a22 4a33 4a44 4a55 4a66 4a77
S 2 7e01 7e12 7e23 7e34 7e45 7e56 7e67 7e78
T 5 01 0
S a
S b
T 6 05 1
S 0 c600 c611 c622 c633 c644 c655 c666 c677
S 4 b001 b102 b203 b304 b405 b506 b607 b708
S 2 d0d0 d1d1 d2d2 d3d3 d4d4 d5d5 d6d6 d7d7
S a
S b
T 7 10 0
S 4 6100 6101 6102 6103 6104 6105 6106 6107
S 2 e0e0 e1e1 e2e2 e3e3 e4e4 e5e5 e6e6 e7e7

/* hif_pkg.sv */
`include "hif_defines.svh"

package hif_pkg;

    // Stream codes as sent in the command word
    typedef enum logic [3:0] {
        STR_CFG    = 4'd0,
        STR_ACT    = 4'd2,
        STR_FLGACT = 4'd4,
        STR_WEI    = 4'd6,
        STR_FLGWEI = 4'd8,
        STR_FLGOFM = 4'd10,
        STR_OFM    = 4'd11
    } stream_e;

    // Layer schedule events
    typedef struct packed {
        logic next_patch;
        logic next_ftrgrp;
        logic reset_patch;
        logic reset_ftrgrp;
        logic reset_ofm;
    } sched_t;

    // Command word with dir high for host to chip
    typedef struct packed {
        logic        dir;
        stream_e     stream;
        logic [10:0] len;
    } host_cmd_t;

    typedef union packed {
        logic [`HIF_DATA_W-1:0] raw;
        host_cmd_t              cmd;
    } host_word_u;

    typedef struct packed {
        logic                   en;
        logic [`GBF_ADDR_W-1:0] addr;
        logic [`HIF_DATA_W-1:0] data;
    } gbf_wr_t;

    typedef struct packed {
        logic                   en;
        logic [`GBF_ADDR_W-1:0] addr;
    } ofm_rd_t;

    // Transfer in flight
    typedef struct packed {
        logic    active;
        logic    dir;
        stream_e stream;
    } xfer_t;

endpackage

/* hif_rx_path.sv */
`timescale 1ns/1ps
`include "hif_defines.svh"

module hif_rx_path (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hif_pkg::xfer_t         xfer,
    input  hif_pkg::sched_t        sched_lev,
    input  logic [`HIF_DATA_W-1:0] host_rx_data,
    input  logic                   host_rx_valid,
    output logic [`HIF_DATA_W-1:0] cfg_data,
    output logic                   cfg_valid,
    output hif_pkg::gbf_wr_t       flgwei_wr,
    output hif_pkg::gbf_wr_t       wei_wr,
    output hif_pkg::gbf_wr_t       flgact_wr,
    output hif_pkg::gbf_wr_t       act_wr
);
    import hif_pkg::*;

    localparam int NUM_WR = 4;

    // Write port order is flgwei, wei, flgact, act
    localparam stream_e WR_STR [NUM_WR] = '{STR_FLGWEI, STR_WEI, STR_FLGACT, STR_ACT};

    logic                   in_act;
    logic                   sel_cfg;
    logic [NUM_WR-1:0]      sel_wr;
    logic [NUM_WR-1:0]      clr_wr;
    logic [`GBF_ADDR_W-1:0] wr_addr [NUM_WR];
    gbf_wr_t                wr_port [NUM_WR];

    assign in_act = xfer.active && xfer.dir;

    // ==================================================================
    // Steering
    // ==================================================================
    assign sel_cfg   = in_act && (xfer.stream == STR_CFG);
    assign cfg_valid = sel_cfg && host_rx_valid;
    assign cfg_data  = sel_cfg ? host_rx_data : '0;

    always_comb begin
        for (int i = 0; i < NUM_WR; i++) begin
            sel_wr[i]       = in_act && (xfer.stream == WR_STR[i]);
            wr_port[i].en   = sel_wr[i] && host_rx_valid;
            wr_port[i].addr = wr_addr[i];
            wr_port[i].data = sel_wr[i] ? host_rx_data : '0;
        end
    end

    // ==================================================================
    // Write address counters
    // ==================================================================
    // next_* events keep the addresses running
    assign clr_wr = {sched_lev.reset_patch, sched_lev.reset_patch,
                     sched_lev.reset_ftrgrp, sched_lev.reset_ftrgrp};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_WR; i++) begin
                wr_addr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_WR; i++) begin
                if (clr_wr[i]) begin
                    wr_addr[i] <= '0;
                end else if (wr_port[i].en) begin
                    wr_addr[i] <= wr_addr[i] + 1'b1;
                end
            end
        end
    end

    assign flgwei_wr = wr_port[0];
    assign wei_wr    = wr_port[1];
    assign flgact_wr = wr_port[2];
    assign act_wr    = wr_port[3];

endmodule

/* hif_top.sv */
`timescale 1ns/1ps
`include "hif_defines.svh"

module hif_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hif_pkg::sched_t        sched,
    input  logic                   cfg_req,
    input  logic [`HIF_DATA_W-1:0] host_rx_data,
    input  logic                   host_rx_valid,
    input  logic                   host_tx_ready,
    input  logic [`HIF_DATA_W-1:0] ofm_rd_data,
    input  logic [`HIF_DATA_W-1:0] flgofm_rd_data,
    output logic                   host_req,
    output hif_pkg::host_word_u    host_tx_data,
    output logic                   host_tx_valid,
    output logic                   xfer_done,
    output logic [`HIF_DATA_W-1:0] cfg_data,
    output logic                   cfg_valid,
    output hif_pkg::gbf_wr_t       flgwei_wr,
    output hif_pkg::gbf_wr_t       wei_wr,
    output hif_pkg::gbf_wr_t       flgact_wr,
    output hif_pkg::gbf_wr_t       act_wr,
    output hif_pkg::ofm_rd_t       flgofm_rd,
    output hif_pkg::ofm_rd_t       ofm_rd
);
    import hif_pkg::*;

    xfer_t                  xfer;
    sched_t                 sched_lev;
    logic                   issue;
    logic [`HIF_DATA_W-1:0] tx_word;
    logic                   tx_valid;

    // ==================================================================
    // Control and framing
    // ==================================================================
    hif_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sched     (sched),
        .cfg_req   (cfg_req),
        .done      (xfer_done),
        .xfer      (xfer),
        .sched_lev (sched_lev),
        .issue     (issue)
    );

    hif_link u_link (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer          (xfer),
        .issue         (issue),
        .host_rx_valid (host_rx_valid),
        .tx_word       (tx_word),
        .tx_valid      (tx_valid),
        .host_req      (host_req),
        .host_tx_data  (host_tx_data),
        .host_tx_valid (host_tx_valid),
        .done          (xfer_done)
    );

    // ==================================================================
    // Buffer side
    // ==================================================================
    hif_rx_path u_rx_path (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer          (xfer),
        .sched_lev     (sched_lev),
        .host_rx_data  (host_rx_data),
        .host_rx_valid (host_rx_valid),
        .cfg_data      (cfg_data),
        .cfg_valid     (cfg_valid),
        .flgwei_wr     (flgwei_wr),
        .wei_wr        (wei_wr),
        .flgact_wr     (flgact_wr),
        .act_wr        (act_wr)
    );

    hif_tx_path u_tx_path (
        .clk            (clk),
        .rst_n          (rst_n),
        .xfer           (xfer),
        .sched_lev      (sched_lev),
        .host_tx_ready  (host_tx_ready),
        .ofm_rd_data    (ofm_rd_data),
        .flgofm_rd_data (flgofm_rd_data),
        .ofm_rd         (ofm_rd),
        .flgofm_rd      (flgofm_rd),
        .tx_word        (tx_word),
        .tx_valid       (tx_valid)
    );

endmodule

/* hif_tx_path.sv */
`timescale 1ns/1ps
`include "hif_defines.svh"

module hif_tx_path (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hif_pkg::xfer_t         xfer,
    input  hif_pkg::sched_t        sched_lev,
    input  logic                   host_tx_ready,
    input  logic [`HIF_DATA_W-1:0] ofm_rd_data,
    input  logic [`HIF_DATA_W-1:0] flgofm_rd_data,
    output hif_pkg::ofm_rd_t       ofm_rd,
    output hif_pkg::ofm_rd_t       flgofm_rd,
    output logic [`HIF_DATA_W-1:0] tx_word,
    output logic                   tx_valid
);
    import hif_pkg::*;

    localparam int NUM_RD = 2;
    localparam int CNT_W  = $clog2(`HIF_BURST_LEN + 1);
    localparam stream_e RD_STR [NUM_RD] = '{STR_FLGOFM, STR_OFM};

    logic                   act_q;
    logic                   rd_go;
    logic                   rd_go_q;
    logic [CNT_W-1:0]       rd_cnt;
    logic [`GBF_ADDR_W-1:0] rd_addr [NUM_RD];
    ofm_rd_t                rd_port [NUM_RD];

    // Reads start the cycle after the command word
    assign rd_go = xfer.active && !xfer.dir && act_q && host_tx_ready &&
                   (rd_cnt != CNT_W'(`HIF_BURST_LEN));

    always_comb begin
        for (int i = 0; i < NUM_RD; i++) begin
            rd_port[i].en   = rd_go && (xfer.stream == RD_STR[i]);
            rd_port[i].addr = rd_addr[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q   <= 1'b0;
            rd_go_q <= 1'b0;
            rd_cnt  <= '0;
        end else begin
            act_q   <= xfer.active;
            rd_go_q <= rd_go;
            if (!xfer.active) begin
                rd_cnt <= '0;
            end else if (rd_go) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Read address counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_RD; i++) begin
                rd_addr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_RD; i++) begin
                if (sched_lev.reset_ofm) begin
                    rd_addr[i] <= '0;
                end else if (rd_port[i].en) begin
                    rd_addr[i] <= rd_addr[i] + 1'b1;
                end
            end
        end
    end

    // Buffer data returns one cycle after the enable
    assign tx_valid  = rd_go_q;
    assign tx_word   = (xfer.stream == STR_FLGOFM) ? flgofm_rd_data : ofm_rd_data;
    assign flgofm_rd = rd_port[0];
    assign ofm_rd    = rd_port[1];

endmodule

/* tb_hif.sv */
`timescale 1ns/1ps
`include "hif_defines.svh"

module tb_hif;
    import hif_pkg::*;

    localparam int MAX_PAT = 16;
    localparam int MAX_STR = 8;
    localparam int BURST   = `HIF_BURST_LEN;

    logic                   clk;
    logic                   rst_n;
    sched_t                 sched;
    logic                   cfg_req;
    logic [`HIF_DATA_W-1:0] host_rx_data;
    logic                   host_rx_valid;
    logic                   host_tx_ready;
    logic [`HIF_DATA_W-1:0] ofm_rd_data;
    logic [`HIF_DATA_W-1:0] flgofm_rd_data;
    logic                   host_req;
    host_word_u             host_tx_data;
    logic                   host_tx_valid;
    logic                   xfer_done;
    logic [`HIF_DATA_W-1:0] cfg_data;
    logic                   cfg_valid;
    gbf_wr_t                flgwei_wr;
    gbf_wr_t                wei_wr;
    gbf_wr_t                flgact_wr;
    gbf_wr_t                act_wr;
    ofm_rd_t                flgofm_rd;
    ofm_rd_t                ofm_rd;

    // Patterns as read from the file
    int                     n_pat;
    int                     pat_id    [MAX_PAT];
    sched_t                 pat_sched [MAX_PAT];
    logic                   pat_cfg   [MAX_PAT];
    int                     pat_nstr  [MAX_PAT];
    logic [3:0]             pat_str   [MAX_PAT*MAX_STR];
    logic [`HIF_DATA_W-1:0] pat_word  [MAX_PAT*MAX_STR*BURST];
    logic                   load_done;

    // Expected buffer addresses by stream code
    logic [`GBF_ADDR_W-1:0] exp_addr [16];
    int                     n_checks;
    int                     n_err;
    int                     n_pass;
    int                     n_fail;

    hif_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_err++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic is_inbound(input logic [3:0] s);
        return !(s == STR_FLGOFM || s == STR_OFM);
    endfunction

    function automatic gbf_wr_t port_of(input logic [3:0] s);
        case (s)
            STR_FLGWEI: return flgwei_wr;
            STR_WEI:    return wei_wr;
            STR_FLGACT: return flgact_wr;
            default:    return act_wr;
        endcase
    endfunction

    function automatic string port_name(input logic [3:0] s);
        case (s)
            STR_FLGWEI: return "flgwei_wr";
            STR_WEI:    return "wei_wr";
            STR_FLGACT: return "flgact_wr";
            default:    return "act_wr";
        endcase
    endfunction

    task automatic report_test(input string name, input int err0);
        if (n_err == err0) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, n_err - err0);
        end
    endtask

    task automatic load_patterns(output bit ok);
        int    fd;
        int    k;
        int    id;
        int    sv;
        int    cv;
        int    code;
        int    idx;
        int    w [BURST];
        string line;
        n_pat = 0;
        fd = $fopen("hif_patterns.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                k = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) == "T" && n_pat < MAX_PAT) begin
                    k = $sscanf(line, "T %h %h %h", id, sv, cv);
                    pat_id[n_pat]    = id;
                    pat_sched[n_pat] = sv[4:0];
                    pat_cfg[n_pat]   = cv[0];
                    pat_nstr[n_pat]  = 0;
                    n_pat++;
                end else if (line.len() > 0 && line.getc(0) == "S" && n_pat > 0) begin
                    k = $sscanf(line, "S %h %h %h %h %h %h %h %h %h", code,
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                    idx = (n_pat - 1) * MAX_STR + pat_nstr[n_pat-1];
                    pat_str[idx] = code[3:0];
                    for (int i = 0; i < BURST; i++) begin
                        pat_word[idx*BURST + i] = w[i][15:0];
                    end
                    pat_nstr[n_pat-1]++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Restart the expected counters the way the schedule events do
    task automatic apply_counter_rules(input sched_t ev);
        if (ev.reset_ftrgrp) begin
            exp_addr[STR_FLGWEI] = '0;
            exp_addr[STR_WEI]    = '0;
        end
        if (ev.reset_patch) begin
            exp_addr[STR_FLGACT] = '0;
            exp_addr[STR_ACT]    = '0;
        end
        if (ev.reset_ofm) begin
            exp_addr[STR_FLGOFM] = '0;
            exp_addr[STR_OFM]    = '0;
        end
    endtask

    task automatic drive_idle();
        sched         = '0;
        cfg_req       = 1'b0;
        host_rx_valid = 1'b0;
        host_rx_data  = '0;
    endtask

    // ======================================================================
    // Host model
    // ======================================================================
    task automatic wait_req(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            drive_idle();
            #1;
            cycles++;
            if (host_req !== 1'b1) begin
                check_value("host_tx_valid", host_tx_valid, 0);
            end
        end while (host_req !== 1'b1);
    endtask

    task automatic send_words(input logic [3:0] s, input int base);
        gbf_wr_t port;
        for (int w = 0; w < BURST; w++) begin
            @(negedge clk);
            host_rx_valid = 1'b1;
            host_rx_data  = pat_word[base + w];
            #1;
            if (s == STR_CFG) begin
                check_value("cfg_valid", cfg_valid, 1);
                check_value("cfg_data", cfg_data, pat_word[base + w]);
            end else begin
                port = port_of(s);
                check_value($sformatf("%s.en", port_name(s)), port.en, 1);
                check_value($sformatf("%s.addr", port_name(s)), port.addr, exp_addr[s]);
                check_value($sformatf("%s.data", port_name(s)), port.data,
                            pat_word[base + w]);
                exp_addr[s]++;
            end
            check_value("xfer_done", xfer_done, w == BURST - 1);
        end
    endtask

    task automatic collect_words(input logic [3:0] s);
        logic [`HIF_DATA_W-1:0] exp;
        logic                   rd_en;
        logic                   rd_en_q;
        string                  rd_name;
        int                     got;
        int                     n_rd;
        got     = 0;
        n_rd    = 0;
        rd_en_q = 1'b0;
        if (s == STR_OFM) begin
            rd_name = "ofm_rd.en";
        end else begin
            rd_name = "flgofm_rd.en";
        end
        while (got < BURST) begin
            @(negedge clk);
            #1;
            // One read per ready cycle until the burst is read
            if (s == STR_OFM) begin
                rd_en = ofm_rd.en;
            end else begin
                rd_en = flgofm_rd.en;
            end
            check_value(rd_name, rd_en, host_tx_ready && n_rd < BURST);
            check_value("host_tx_valid", host_tx_valid, rd_en_q);
            if (host_tx_valid) begin
                // Buffer contents follow from the read address
                if (s == STR_OFM) begin
                    exp = `HIF_DATA_W'(exp_addr[s]) ^ 16'hA5A5;
                end else begin
                    exp = `HIF_DATA_W'(exp_addr[s]) + 16'h1000;
                end
                check_value("host_tx_data", host_tx_data.raw, exp);
                exp_addr[s]++;
                got++;
            end
            check_value("xfer_done", xfer_done, host_tx_valid && got == BURST);
            if (rd_en) begin
                n_rd++;
            end
            rd_en_q = rd_en;
        end
    endtask

    task automatic run_pattern(input int p);
        int         cycles;
        int         err0;
        int         idx;
        logic [3:0] s;
        err0 = n_err;
        @(negedge clk);
        drive_idle();
        sched   = pat_sched[p];
        cfg_req = pat_cfg[p];
        #1;
        apply_counter_rules(pat_sched[p]);
        for (int i = 0; i < pat_nstr[p]; i++) begin
            idx = p * MAX_STR + i;
            s   = pat_str[idx];
            wait_req(cycles);
            if (i == 0) begin
                check_value("host_req latency", cycles, 2);
            end
            check_value("host_tx_data.cmd.dir", host_tx_data.cmd.dir, is_inbound(s));
            check_value("host_tx_data.cmd.stream", host_tx_data.cmd.stream, s);
            check_value("host_tx_data.cmd.len", host_tx_data.cmd.len, BURST);
            if (is_inbound(s)) begin
                send_words(s, idx * BURST);
            end else begin
                collect_words(s);
            end
        end
        report_test($sformatf("%0d", pat_id[p]), err0);
    endtask

    // ======================================================================
    // Buffer model and host ready
    // ======================================================================
    initial begin : buffer_model
        ofm_rd_t ofm_q;
        ofm_rd_t flg_q;
        int      seed_ret;
        ofm_q    = '0;
        flg_q    = '0;
        seed_ret = $urandom(32'h88ea);
        forever begin
            @(negedge clk);
            // Read data comes back one cycle after the enable
            if (ofm_q.en) begin
                ofm_rd_data = `HIF_DATA_W'(ofm_q.addr) ^ 16'hA5A5;
            end
            if (flg_q.en) begin
                flgofm_rd_data = `HIF_DATA_W'(flg_q.addr) + 16'h1000;
            end
            host_tx_ready = ($urandom % 4) != 0;
            #1;
            ofm_q = ofm_rd;
            flg_q = flgofm_rd;
        end
    end

    initial begin : watchdog
        int limit;
        wait (load_done === 1'b1);
        limit = n_pat * 4 * BURST + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin : main_seq
        int err0;
        bit load_ok;
        rst_n          = 1'b0;
        sched          = '0;
        cfg_req        = 1'b0;
        host_rx_data   = '0;
        host_rx_valid  = 1'b0;
        host_tx_ready  = 1'b0;
        ofm_rd_data    = '0;
        flgofm_rd_data = '0;
        n_checks       = 0;
        n_err          = 0;
        n_pass         = 0;
        n_fail         = 0;
        load_done      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp_addr[i] = '0;
        end
        load_patterns(load_ok);
        load_done = 1'b1;
        if (!load_ok) begin
            $display("Could not open hif_patterns.txt, no test was run");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (16) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            #1;
            err0 = n_err;
            check_value("host_req", host_req, 0);
            check_value("host_tx_valid", host_tx_valid, 0);
            check_value("xfer_done", xfer_done, 0);
            check_value("cfg_valid", cfg_valid, 0);
            check_value("flgwei_wr.en", flgwei_wr.en, 0);
            check_value("wei_wr.en", wei_wr.en, 0);
            check_value("flgact_wr.en", flgact_wr.en, 0);
            check_value("act_wr.en", act_wr.en, 0);
            check_value("flgofm_rd.en", flgofm_rd.en, 0);
            check_value("ofm_rd.en", ofm_rd.en, 0);
            report_test("reset", err0);
            for (int p = 0; p < n_pat; p++) begin
                run_pattern(p);
            end
            $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                     n_pass + n_fail, n_pass, n_fail, n_checks, n_err);
            if (n_err == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule
